// ==== build.f ====
src/gbe_pkg.sv
src/gbe_tx_framer.sv
src/gbe_frame_fifo.sv
src/gbe_rx_parser.sv
src/gbe_loopback_top.sv
tb/tb_gbe_loopback.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_gbe_loopback -o sim_tb

./obj_dir/sim_tb | tee sim.log

# Pass only when the testbench printed its pass line
grep -q "PASS: all tests" sim.log
echo "simulation passed"

// ==== tb/tb_gbe_loopback.sv ====
`timescale 1ns/1ps

module tb_gbe_loopback;

    import gbe_pkg::*;

    localparam ip_addr_t  LOCAL_IP    = 32'h0a00_0001;
    localparam udp_port_t LOCAL_PORT  = 16'd10000;
    localparam int        FIFO_DEPTH  = 16;
    localparam int        AFULL_LEVEL = 12;

    localparam logic [1:0] ACK_ALWAYS = 2'd0;
    localparam logic [1:0] ACK_LFSR   = 2'd1;
    localparam logic [1:0] ACK_HOLD   = 2'd2;

    localparam int NUM_ENTRIES = 9;

    // One frame per row, ovf is the expected overflow flag after the row
    typedef struct packed {
        ip_addr_t   dip;
        udp_port_t  dport;
        int         beats;
        int         gap;
        logic [1:0] ack;
        logic       ovf;
        logic       rst_after;
    } frame_entry_t;

    frame_entry_t frame_table [NUM_ENTRIES] = '{
        '{32'h0a00_0001, 16'd10000, 4,  2, ACK_ALWAYS, 1'b0, 1'b0},
        '{32'h0a00_0002, 16'd10000, 6,  1, ACK_LFSR,   1'b0, 1'b0},
        '{32'h0a00_0001, 16'd10001, 1,  3, ACK_LFSR,   1'b0, 1'b0},
        '{32'h0a00_0001, 16'd10000, 13, 2, ACK_HOLD,   1'b0, 1'b0},
        // Zero gap, so the next frame is discarded
        '{32'h0a00_0001, 16'd10000, 9,  0, ACK_ALWAYS, 1'b0, 1'b0},
        '{32'hc0a8_0001, 16'd20000, 5,  2, ACK_ALWAYS, 1'b1, 1'b0},
        // Reset clears the overflow left by the discarded frame
        '{32'h0a00_0001, 16'd10000, 3,  2, ACK_LFSR,   1'b1, 1'b1},
        // More payload than the FIFO can hold
        '{32'h0a00_0001, 16'd10000, 18, 2, ACK_HOLD,   1'b1, 1'b1},
        '{32'h0a00_0003, 16'd10000, 7,  2, ACK_LFSR,   1'b0, 1'b0}
    };

    logic       user_clk;
    logic       rst_n;
    logic       gbe_tx_afull;
    logic       gbe_tx_overflow;
    ip_addr_t   gbe_tx_dest_ip;
    udp_port_t  gbe_tx_dest_port;
    data_word_t gbe_tx_data;
    logic [VALID_W-1:0] gbe_tx_valid;
    logic       gbe_tx_end_of_frame;
    logic       gbe_rx_ack;
    data_word_t gbe_rx_data;
    logic [VALID_W-1:0] gbe_rx_valid;
    ip_addr_t   gbe_rx_source_ip;
    udp_port_t  gbe_rx_source_port;
    ip_addr_t   gbe_rx_dest_ip;
    udp_port_t  gbe_rx_dest_port;
    logic       gbe_rx_end_of_frame;
    logic       gbe_rx_bad_frame;

    logic [1:0]  ack_mode;
    logic [31:0] tx_lfsr;
    logic [31:0] ack_lfsr;
    logic        prev_gap_zero;

    // Expected receive stream
    data_word_t exp_data [$];
    logic       exp_eof [$];
    ip_addr_t   exp_dip [$];
    udp_port_t  exp_dport [$];
    logic       exp_bad [$];

    gbe_loopback_top #(
        .LOCAL_IP    (LOCAL_IP),
        .LOCAL_PORT  (LOCAL_PORT),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .AFULL_LEVEL (AFULL_LEVEL)
    ) i_gbe_loopback_top (
        .user_clk            (user_clk),
        .rst_n               (rst_n),
        .gbe_tx_afull        (gbe_tx_afull),
        .gbe_tx_overflow     (gbe_tx_overflow),
        .gbe_tx_dest_ip      (gbe_tx_dest_ip),
        .gbe_tx_dest_port    (gbe_tx_dest_port),
        .gbe_tx_data         (gbe_tx_data),
        .gbe_tx_valid        (gbe_tx_valid),
        .gbe_tx_end_of_frame (gbe_tx_end_of_frame),
        .gbe_rx_ack          (gbe_rx_ack),
        .gbe_rx_data         (gbe_rx_data),
        .gbe_rx_valid        (gbe_rx_valid),
        .gbe_rx_source_ip    (gbe_rx_source_ip),
        .gbe_rx_source_port  (gbe_rx_source_port),
        .gbe_rx_dest_ip      (gbe_rx_dest_ip),
        .gbe_rx_dest_port    (gbe_rx_dest_port),
        .gbe_rx_end_of_frame (gbe_rx_end_of_frame),
        .gbe_rx_bad_frame    (gbe_rx_bad_frame)
    );

    always begin
        #50 user_clk = ~user_clk;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic data_word_t next_word();
        data_word_t w;
        for (int k = 0; k < DATA_W; k++) begin
            w[k]    = tx_lfsr[0];
            tx_lfsr = lfsr_step(tx_lfsr);
        end
        return w;
    endfunction

    task automatic report_fail();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input data_word_t exp, input data_word_t got);
        assert (exp === got) else begin
            $display("mismatch %s exp=%h got=%h", name, exp, got);
            report_fail();
        end
    endtask

    always @(posedge user_clk) begin
        case (ack_mode)
            ACK_ALWAYS: gbe_rx_ack <= 1'b1;
            ACK_LFSR: begin
                gbe_rx_ack <= ack_lfsr[0];
                ack_lfsr   <= lfsr_step(ack_lfsr);
            end
            default: gbe_rx_ack <= 1'b0;
        endcase
    end

    // Receive monitor, sampled mid-cycle
    always @(negedge user_clk) begin
        if (rst_n) begin
            assert (gbe_rx_valid == 4'h0 || gbe_rx_valid == 4'hf) else begin
                $display("gbe_rx_valid strobes disagree: %h", gbe_rx_valid);
                report_fail();
            end
            if (gbe_rx_valid == 4'hf && gbe_rx_ack) begin
                assert (exp_data.size() > 0) else begin
                    $display("received a beat that was never sent");
                    report_fail();
                end
                check_val("gbe_rx_data", exp_data.pop_front(), gbe_rx_data);
                check_val("gbe_rx_end_of_frame", DATA_W'(exp_eof.pop_front()),
                          DATA_W'(gbe_rx_end_of_frame));
                check_val("gbe_rx_bad_frame", DATA_W'(exp_bad.pop_front()),
                          DATA_W'(gbe_rx_bad_frame));
                check_val("gbe_rx_source_ip", DATA_W'(LOCAL_IP), DATA_W'(gbe_rx_source_ip));
                check_val("gbe_rx_source_port", DATA_W'(LOCAL_PORT),
                          DATA_W'(gbe_rx_source_port));
                check_val("gbe_rx_dest_ip", DATA_W'(exp_dip.pop_front()),
                          DATA_W'(gbe_rx_dest_ip));
                check_val("gbe_rx_dest_port", DATA_W'(exp_dport.pop_front()),
                          DATA_W'(gbe_rx_dest_port));
            end
        end
    end

    task automatic apply_reset();
        @(posedge user_clk);
        rst_n        <= 1'b0;
        gbe_tx_valid <= '0;
        repeat (3) @(posedge user_clk);
        rst_n         <= 1'b1;
        prev_gap_zero  = 1'b0;
        exp_data.delete();
        exp_eof.delete();
        exp_dip.delete();
        exp_dport.delete();
        exp_bad.delete();
        @(negedge user_clk);
        check_val("gbe_tx_overflow", '0, DATA_W'(gbe_tx_overflow));
        check_val("gbe_tx_afull", '0, DATA_W'(gbe_tx_afull));
        check_val("gbe_rx_valid", '0, DATA_W'(gbe_rx_valid));
        check_val("gbe_rx_bad_frame", '0, DATA_W'(gbe_rx_bad_frame));
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < max_cycles) begin
            @(posedge user_clk);
            n++;
        end
        assert (exp_data.size() == 0) else begin
            $display("timeout: %0d expected beats never came out", exp_data.size());
            report_fail();
        end
    endtask

    // FIFO fill with the receive side blocked, at the negedge after the
    // edge_idx-th rising edge, edge 0 being where the first beat is driven
    task automatic check_afull_level(input int edge_idx, input int beats);
        int fill;
        fill = 0;
        // Header stays one cycle until the parser strips it
        if (edge_idx == 2) begin
            fill = 1;
        end
        // Beat k is accepted at edge k+1 and enters the FIFO at edge k+3
        if (edge_idx >= 3) begin
            fill = edge_idx - 2;
        end
        if (fill > beats) begin
            fill = beats;
        end
        if (fill > FIFO_DEPTH) begin
            fill = FIFO_DEPTH;
        end
        @(negedge user_clk);
        check_val("gbe_tx_afull", DATA_W'(fill >= AFULL_LEVEL), DATA_W'(gbe_tx_afull));
    endtask

    task automatic send_frame(input frame_entry_t e);
        logic       drop;
        logic       keep;
        data_word_t w;
        drop = prev_gap_zero;
        for (int i = 0; i < e.beats; i++) begin
            w = next_word();
            @(posedge user_clk);
            // Walk the strobe bits, any one of them marks a beat
            gbe_tx_valid        <= VALID_W'(1) << i[1:0];
            gbe_tx_data         <= w;
            gbe_tx_end_of_frame <= (i == e.beats - 1);
            gbe_tx_dest_ip      <= e.dip;
            gbe_tx_dest_port    <= e.dport;
            // With the header stripped, a blocked FIFO keeps FIFO_DEPTH payload beats
            keep = !drop && !(e.ack == ACK_HOLD && i >= FIFO_DEPTH);
            if (keep) begin
                exp_data.push_back(w);
                exp_eof.push_back(i == e.beats - 1);
                exp_dip.push_back(e.dip);
                exp_dport.push_back(e.dport);
                exp_bad.push_back((i == e.beats - 1) &&
                                  (e.dip != LOCAL_IP || e.dport != LOCAL_PORT));
            end
            if (e.ack == ACK_HOLD) begin
                check_afull_level(i, e.beats);
            end
        end
        for (int g = 0; g < e.gap; g++) begin
            @(posedge user_clk);
            gbe_tx_valid        <= '0;
            gbe_tx_end_of_frame <= 1'b0;
            if (e.ack == ACK_HOLD) begin
                check_afull_level(e.beats + g, e.beats);
            end
        end
        prev_gap_zero = (e.gap == 0);
    endtask

    initial begin
        user_clk            = 1'b0;
        rst_n               = 1'b0;
        gbe_tx_dest_ip      = '0;
        gbe_tx_dest_port    = '0;
        gbe_tx_data         = '0;
        gbe_tx_valid        = '0;
        gbe_tx_end_of_frame = 1'b0;
        gbe_rx_ack          = 1'b0;
        ack_mode            = ACK_ALWAYS;
        tx_lfsr             = 32'h5e8f_8b73;
        ack_lfsr            = 32'h5e8f_8b73;
        prev_gap_zero       = 1'b0;

        apply_reset();

        for (int t = 0; t < NUM_ENTRIES; t++) begin
            if (frame_table[t].ack == ACK_HOLD) begin
                // Start a blocked frame from an empty FIFO
                wait_drain(500);
                repeat (2) @(negedge user_clk);
                check_val("gbe_tx_afull", '0, DATA_W'(gbe_tx_afull));
                @(posedge user_clk);
            end
            ack_mode <= frame_table[t].ack;
            send_frame(frame_table[t]);
            if (frame_table[t].ack == ACK_HOLD) begin
                repeat (2) @(negedge user_clk);
                check_val("gbe_tx_overflow", DATA_W'(frame_table[t].ovf),
                          DATA_W'(gbe_tx_overflow));
                @(posedge user_clk);
                ack_mode <= ACK_ALWAYS;
                wait_drain(500);
            end
            if (frame_table[t].gap != 0) begin
                @(negedge user_clk);
                check_val("gbe_tx_overflow", DATA_W'(frame_table[t].ovf),
                          DATA_W'(gbe_tx_overflow));
            end
            if (frame_table[t].rst_after) begin
                wait_drain(500);
                apply_reset();
            end
        end

        ack_mode <= ACK_ALWAYS;
        wait_drain(500);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== src/gbe_loopback_top.sv ====
`timescale 1ns/1ps

module gbe_loopback_top #(
    parameter gbe_pkg::ip_addr_t  LOCAL_IP    = 32'h0a00_0001,
    parameter gbe_pkg::udp_port_t LOCAL_PORT  = 16'd10000,
    parameter int                 FIFO_DEPTH  = 16,
    parameter int                 AFULL_LEVEL = 12
) (
    input  logic                         user_clk,
    input  logic                         rst_n,

    // User transmit side
    output logic                         gbe_tx_afull,
    output logic                         gbe_tx_overflow,
    input  gbe_pkg::ip_addr_t            gbe_tx_dest_ip,
    input  gbe_pkg::udp_port_t           gbe_tx_dest_port,
    input  gbe_pkg::data_word_t          gbe_tx_data,
    input  logic [gbe_pkg::VALID_W-1:0]  gbe_tx_valid,
    input  logic                         gbe_tx_end_of_frame,

    // User receive side
    input  logic                         gbe_rx_ack,
    output gbe_pkg::data_word_t          gbe_rx_data,
    output logic [gbe_pkg::VALID_W-1:0]  gbe_rx_valid,
    output gbe_pkg::ip_addr_t            gbe_rx_source_ip,
    output gbe_pkg::udp_port_t           gbe_rx_source_port,
    output gbe_pkg::ip_addr_t            gbe_rx_dest_ip,
    output gbe_pkg::udp_port_t           gbe_rx_dest_port,
    output logic                         gbe_rx_end_of_frame,
    output logic                         gbe_rx_bad_frame
);

    import gbe_pkg::*;

    // Framer to FIFO
    logic       wr_en;
    link_beat_t wr_beat;
    logic       full;

    // FIFO to parser
    link_beat_t head;
    logic       empty;
    logic       rd_en;

    gbe_tx_framer #(
        .LOCAL_IP   (LOCAL_IP),
        .LOCAL_PORT (LOCAL_PORT)
    ) i_gbe_tx_framer (
        .user_clk            (user_clk),
        .rst_n               (rst_n),
        .gbe_tx_data         (gbe_tx_data),
        .gbe_tx_valid        (gbe_tx_valid),
        .gbe_tx_end_of_frame (gbe_tx_end_of_frame),
        .gbe_tx_dest_ip      (gbe_tx_dest_ip),
        .gbe_tx_dest_port    (gbe_tx_dest_port),
        .full                (full),
        .wr_en               (wr_en),
        .wr_beat             (wr_beat),
        .gbe_tx_overflow     (gbe_tx_overflow)
    );

    // Loopback in place of the MAC and link
    gbe_frame_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .AFULL_LEVEL (AFULL_LEVEL)
    ) i_gbe_frame_fifo (
        .user_clk (user_clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_beat  (wr_beat),
        .rd_en    (rd_en),
        .head     (head),
        .empty    (empty),
        .full     (full),
        .afull    (gbe_tx_afull)
    );

    gbe_rx_parser #(
        .LOCAL_IP   (LOCAL_IP),
        .LOCAL_PORT (LOCAL_PORT)
    ) i_gbe_rx_parser (
        .user_clk            (user_clk),
        .rst_n               (rst_n),
        .head                (head),
        .empty               (empty),
        .gbe_rx_ack          (gbe_rx_ack),
        .rd_en               (rd_en),
        .gbe_rx_data         (gbe_rx_data),
        .gbe_rx_valid        (gbe_rx_valid),
        .gbe_rx_end_of_frame (gbe_rx_end_of_frame),
        .gbe_rx_bad_frame    (gbe_rx_bad_frame),
        .gbe_rx_source_ip    (gbe_rx_source_ip),
        .gbe_rx_dest_ip      (gbe_rx_dest_ip),
        .gbe_rx_source_port  (gbe_rx_source_port),
        .gbe_rx_dest_port    (gbe_rx_dest_port)
    );

endmodule

// ==== src/gbe_rx_parser.sv ====
`timescale 1ns/1ps

module gbe_rx_parser #(
    parameter gbe_pkg::ip_addr_t  LOCAL_IP   = 32'h0a00_0001,
    parameter gbe_pkg::udp_port_t LOCAL_PORT = 16'd10000
) (
    input  logic                         user_clk,
    input  logic                         rst_n,
    input  gbe_pkg::link_beat_t          head,
    input  logic                         empty,
    input  logic                         gbe_rx_ack,
    output logic                         rd_en,
    output gbe_pkg::data_word_t          gbe_rx_data,
    output logic [gbe_pkg::VALID_W-1:0]  gbe_rx_valid,
    output logic                         gbe_rx_end_of_frame,
    output logic                         gbe_rx_bad_frame,
    output gbe_pkg::ip_addr_t            gbe_rx_source_ip,
    output gbe_pkg::ip_addr_t            gbe_rx_dest_ip,
    output gbe_pkg::udp_port_t           gbe_rx_source_port,
    output gbe_pkg::udp_port_t           gbe_rx_dest_port
);

    import gbe_pkg::*;

    rx_state_t  state;
    rx_state_t  state_next;
    frame_hdr_t head_hdr;
    logic       payload_valid;
    logic       hdr_pop;
    logic       addr_mismatch;

    // Header fields sit in the low bits of the header beat
    assign head_hdr = head.data[HDR_W-1:0];

    assign payload_valid = (state == RX_PAYLOAD) && !empty;
    assign hdr_pop       = (state == RX_HEADER) && !empty && head.is_header;

    // Next state and pop control
    always_comb begin
        rd_en      = 1'b0;
        state_next = state;
        case (state)
            RX_HEADER: begin
                // Header is stripped without an ack
                // Stray payload beats are dropped to resync after a loss
                if (!empty) begin
                    rd_en = 1'b1;
                    if (head.is_header) begin
                        state_next = RX_PAYLOAD;
                    end
                end
            end
            RX_PAYLOAD: begin
                if (payload_valid && gbe_rx_ack) begin
                    rd_en = 1'b1;
                    if (head.eof) begin
                        state_next = RX_HEADER;
                    end
                end
            end
            default: begin
                state_next = RX_HEADER;
            end
        endcase
    end

    always_ff @(posedge user_clk) begin
        if (!rst_n) begin
            state <= RX_HEADER;
        end else begin
            state <= state_next;
        end
    end

    // Address fields held for the whole frame
    always_ff @(posedge user_clk) begin
        if (hdr_pop) begin
            gbe_rx_source_ip   <= head_hdr.src_ip;
            gbe_rx_source_port <= head_hdr.src_port;
            gbe_rx_dest_ip     <= head_hdr.dst_ip;
            gbe_rx_dest_port   <= head_hdr.dst_port;
        end
    end

    // Evaluated once per frame on the header
    always_ff @(posedge user_clk) begin
        if (!rst_n) begin
            addr_mismatch <= 1'b0;
        end else if (hdr_pop) begin
            addr_mismatch <= (head_hdr.dst_ip != LOCAL_IP) ||
                             (head_hdr.dst_port != LOCAL_PORT);
        end
    end

    // Payload presented straight from the FIFO head
    assign gbe_rx_data         = head.data;
    assign gbe_rx_valid        = {VALID_W{payload_valid}};
    assign gbe_rx_end_of_frame = payload_valid && head.eof;

    // Mismatched frames are still delivered, only flagged
    assign gbe_rx_bad_frame = gbe_rx_end_of_frame && addr_mismatch;

endmodule

// ==== src/gbe_frame_fifo.sv ====
`timescale 1ns/1ps

module gbe_frame_fifo #(
    parameter int FIFO_DEPTH  = 16,
    parameter int AFULL_LEVEL = 12
) (
    input  logic                user_clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  gbe_pkg::link_beat_t wr_beat,
    input  logic                rd_en,
    output gbe_pkg::link_beat_t head,
    output logic                empty,
    output logic                full,
    output logic                afull
);

    import gbe_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = AW + 1;

    localparam logic [CW-1:0] FULL_COUNT  = CW'(FIFO_DEPTH);
    localparam logic [CW-1:0] AFULL_COUNT = CW'(AFULL_LEVEL);

    // Stands in for the MAC and the 100G link
    link_beat_t mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    // Writes into a full FIFO are lost
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty = (count == '0);
    assign full  = (count == FULL_COUNT);
    assign afull = (count >= AFULL_COUNT);

    // Oldest beat always on the output
    assign head = mem[rd_ptr];

    always_ff @(posedge user_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge user_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge user_clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/gbe_tx_framer.sv ====
`timescale 1ns/1ps

module gbe_tx_framer #(
    parameter gbe_pkg::ip_addr_t  LOCAL_IP   = 32'h0a00_0001,
    parameter gbe_pkg::udp_port_t LOCAL_PORT = 16'd10000
) (
    input  logic                         user_clk,
    input  logic                         rst_n,
    input  gbe_pkg::data_word_t          gbe_tx_data,
    input  logic [gbe_pkg::VALID_W-1:0]  gbe_tx_valid,
    input  logic                         gbe_tx_end_of_frame,
    input  gbe_pkg::ip_addr_t            gbe_tx_dest_ip,
    input  gbe_pkg::udp_port_t           gbe_tx_dest_port,
    input  logic                         full,
    output logic                         wr_en,
    output gbe_pkg::link_beat_t          wr_beat,
    output logic                         gbe_tx_overflow
);

    import gbe_pkg::*;

    logic       accept;
    logic       in_frame;
    logic       last_eof;
    logic       drop_active;
    logic       frame_start;
    logic       gap_violation;
    logic       hdr_write;
    logic       discard;
    frame_hdr_t tx_hdr;

    // Payload delay stage ahead of the output register
    logic       s1_valid;
    logic       s1_eof;
    data_word_t s1_data;

    // Any strobe bit counts as a beat
    assign accept = |gbe_tx_valid;

    assign frame_start = accept && !in_frame;

    // A header one cycle after an eof would collide with that eof's payload write
    assign gap_violation = frame_start && last_eof;
    assign hdr_write     = frame_start && !gap_violation;

    // Beats of a frame that lost its header slot
    assign discard = accept && (drop_active || gap_violation);

    // Header built from the destination seen with the first beat
    always_comb begin
        tx_hdr.src_ip   = LOCAL_IP;
        tx_hdr.src_port = LOCAL_PORT;
        tx_hdr.dst_ip   = gbe_tx_dest_ip;
        tx_hdr.dst_port = gbe_tx_dest_port;
    end

    // Frame boundary tracking
    always_ff @(posedge user_clk) begin
        if (!rst_n) begin
            in_frame    <= 1'b0;
            last_eof    <= 1'b0;
            drop_active <= 1'b0;
        end else begin
            last_eof <= accept && gbe_tx_end_of_frame;
            if (accept) begin
                in_frame    <= !gbe_tx_end_of_frame;
                drop_active <= discard && !gbe_tx_end_of_frame;
            end
        end
    end

    always_ff @(posedge user_clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept && !discard;
        end
    end

    always_ff @(posedge user_clk) begin
        if (accept) begin
            s1_data <= gbe_tx_data;
            s1_eof  <= gbe_tx_end_of_frame;
        end
    end

    // Output stage, header one cycle after the first beat,
    // payload two cycles after its beat
    always_ff @(posedge user_clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= hdr_write || s1_valid;
        end
    end

    always_ff @(posedge user_clk) begin
        if (hdr_write) begin
            wr_beat.is_header <= 1'b1;
            wr_beat.eof       <= 1'b0;
            wr_beat.data      <= {{HDR_PAD_W{1'b0}}, tx_hdr};
        end else begin
            wr_beat.is_header <= 1'b0;
            wr_beat.eof       <= s1_eof;
            wr_beat.data      <= s1_data;
        end
    end

    // Sticky until reset
    always_ff @(posedge user_clk) begin
        if (!rst_n) begin
            gbe_tx_overflow <= 1'b0;
        end else if (gap_violation || (wr_en && full)) begin
            gbe_tx_overflow <= 1'b1;
        end
    end

endmodule

// ==== src/gbe_pkg.sv ====
package gbe_pkg;

    // Beat and field widths of the user stream
    localparam int DATA_W  = 512;
    localparam int VALID_W = 4;
    localparam int IP_W    = 32;
    localparam int PORT_W  = 16;

    // Header fields occupy the low bits of a header beat
    localparam int HDR_W     = 2 * IP_W + 2 * PORT_W;
    localparam int HDR_PAD_W = DATA_W - HDR_W;

    // Link word is the data beat plus two marker bits
    localparam int BEAT_W = DATA_W + 2;

    // One full 512-bit beat, payload or header
    typedef logic [DATA_W-1:0] data_word_t;

    // IPv4 address
    typedef logic [IP_W-1:0] ip_addr_t;

    // UDP port number
    typedef logic [PORT_W-1:0] udp_port_t;

    // Addressing carried in the header beat
    // Source fields are the sender's own address
    typedef struct packed {
        ip_addr_t  src_ip;
        udp_port_t src_port;
        ip_addr_t  dst_ip;
        udp_port_t dst_port;
    } frame_hdr_t;

    // Word stored in the frame FIFO
    // is_header marks the first beat of a frame, eof the last payload beat
    typedef struct packed {
        logic       is_header;
        logic       eof;
        data_word_t data;
    } link_beat_t;

    // Receive parser states
    typedef enum logic {
        RX_HEADER  = 1'b0,
        RX_PAYLOAD = 1'b1
    } rx_state_t;

endpackage
